// ==== files.f ====
+incdir+design
design/tcb_lite_pkg.sv
design/tcb_lite_lib_logsize2byteena.sv
design/tcb_lite_lib_decoder.sv
design/tcb_lite_mem.sv
design/tcb_lite_csr.sv
design/tcb_lite_top.sv
tb/tcb_lite_tb.sv

// ==== tb/tcb_lite_tb.sv ====
// tcb-lite subordinate testbench with a byte-level reference model and directed and random transfers
`timescale 1ns/1ns
`include "tcb_lite_settings.svh"

module tcb_lite_tb;

    localparam int N_PLAN = 3 + 256 + 42 + 23 + 7 + 5 + 400;  // transfers in all sections

    // expected response plus whether rdt matters
    typedef struct packed {
        tcb_lite_pkg::tcb_rsp_t rsp;
        logic                   wen;  // write responses carry no data
    } pend_t;

    logic                   clk;
    logic                   rst;
    logic                   sub_vld;
    logic                   sub_lck;
    logic                   sub_ndn;
    logic                   sub_wen;
    tcb_lite_pkg::tcb_adr_t sub_adr;
    tcb_lite_pkg::tcb_siz_t sub_siz;
    tcb_lite_pkg::tcb_byt_t sub_byt;
    tcb_lite_pkg::tcb_dat_t sub_wdt;
    logic                   sub_rdy;
    tcb_lite_pkg::tcb_dat_t sub_rdt;
    logic                   sub_err;

    // shadows of the subsystem state
    tcb_lite_pkg::tcb_dat_t shd_mem [0:`TCB_MEM_WORDS-1];
    logic                   shd_wp;
    tcb_lite_pkg::tcb_dat_t shd_scr;
    tcb_lite_pkg::tcb_dat_t shd_cnt;  // accepted memory writes

    pend_t exp_q [$];   // one entry per transfer in flight
    logic  chk;         // transfer taken at the last rising edge
    int    n_sent;
    int    n_checked;

    // unmapped addresses just past each window and far away
    tcb_lite_pkg::tcb_adr_t sel_adr_list [4] = '{
        32'h0000_0400, 32'h0000_1010, 32'h0000_2000, 32'hffff_fffc
    };

    tcb_lite_top UUT (
        .clk (clk), .rst (rst),
        .sub_vld (sub_vld), .sub_lck (sub_lck), .sub_ndn (sub_ndn), .sub_wen (sub_wen),
        .sub_adr (sub_adr), .sub_siz (sub_siz), .sub_byt (sub_byt), .sub_wdt (sub_wdt),
        .sub_rdy (sub_rdy), .sub_rdt (sub_rdt), .sub_err (sub_err)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // works byte by byte on addresses rather than on bus lanes
    function automatic tcb_lite_pkg::tcb_rsp_t expect_rsp(
        input logic                   wen,
        input logic                   ndn,
        input tcb_lite_pkg::tcb_adr_t adr,
        input tcb_lite_pkg::tcb_siz_t siz,
        input tcb_lite_pkg::tcb_dat_t wdt
    );
        tcb_lite_pkg::tcb_rsp_t rsp;
        tcb_lite_pkg::tcb_dat_t word;  // addressed word before and after the write
        int   nb;                      // bytes in transfer
        int   lane;
        int   src;                     // byte position in wdt/rdt
        int   widx;
        logic in_mem;
        logic in_csr;
        nb      = 1 << siz;
        in_mem  = (adr >= `TCB_MEM_BASE) && (adr < `TCB_MEM_BASE + 4 * `TCB_MEM_WORDS);
        in_csr  = (adr >= `TCB_CSR_BASE) && (adr < `TCB_CSR_BASE + 16);
        rsp.err = !(in_mem || in_csr) || ((adr % nb) != 0) || (in_mem && wen && shd_wp);
        rsp.rdt = '0;
        if (rsp.err) return rsp;  // nothing stored and reads give 0
        widx = in_mem ? (adr - `TCB_MEM_BASE) >> 2 : (adr - `TCB_CSR_BASE) >> 2;
        if (in_mem) begin
            word = shd_mem[widx];
        end else begin
            case (widx)
                0:       word = {31'd0, shd_wp};
                1:       word = shd_scr;
                2:       word = shd_cnt;
                default: word = `TCB_CSR_ID;
            endcase
        end
        for (int k = 0; k < nb; k++) begin
            lane = adr[1:0] + k;
            src  = ndn ? (nb - 1 - k) : k;  // big endian puts the msb at the lowest address
            if (wen) word[8*lane +: 8] = wdt[8*src +: 8];
            else     rsp.rdt[8*src +: 8] = word[8*lane +: 8];
        end
        if (wen) begin
            if (in_mem) begin
                shd_mem[widx] = word;
                shd_cnt       = shd_cnt + 32'd1;
            end else if ((widx == 0) && (adr[1:0] == 2'd0)) begin
                shd_wp = word[0];  // only when lane 0 is written
            end else if (widx == 1) begin
                shd_scr = word;
            end
        end
        return rsp;
    endfunction

    // initial memory image built from the whole word index
    function automatic tcb_lite_pkg::tcb_dat_t fill_pattern(input int idx);
        logic [7:0] i;
        i = idx[7:0];
        return {i ^ 8'ha5, i, ~i, i * 8'd3};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rdt(
        input tcb_lite_pkg::tcb_dat_t got,
        input tcb_lite_pkg::tcb_dat_t exp
    );
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t ns: rdt %h, expected %h", $time, got, exp));
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t ns: err %b, expected %b", $time, got, exp));
    endtask

    always @(posedge clk) chk <= !rst && sub_vld && sub_rdy;

    // response sits in the cycle after the transfer and is stable at the falling edge
    always @(negedge clk) begin
        pend_t ent;
        if (chk) begin
            ent = exp_q.pop_front();
            check_err(sub_err, ent.rsp.err);
            if (!ent.wen) check_rdt(sub_rdt, ent.rsp.rdt);
            n_checked++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // clock, stimulus, watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        repeat (N_PLAN * 2 + 100) @(posedge clk);
        $display("timeout: the test did not finish within %0d cycles", N_PLAN * 2 + 100);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    // one transfer driven at the falling edge
    task automatic drive_req(
        input logic                   wen,
        input logic                   ndn,
        input tcb_lite_pkg::tcb_adr_t adr,
        input tcb_lite_pkg::tcb_siz_t siz,
        input tcb_lite_pkg::tcb_dat_t wdt
    );
        pend_t ent;
        @(negedge clk);
        sub_vld = 1'b1;
        sub_wen = wen;
        sub_ndn = ndn;
        sub_adr = adr;
        sub_siz = siz;
        sub_wdt = wdt;
        sub_lck = $urandom % 2;  // carried with no effect
        ent.rsp = expect_rsp(wen, ndn, adr, siz, wdt);
        ent.wen = wen;
        exp_q.push_back(ent);
        n_sent++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        sub_vld = 1'b0;
    endtask

    initial begin
        int sel;
        tcb_lite_pkg::tcb_adr_t adr;
        tcb_lite_pkg::tcb_siz_t siz;
        void'($urandom(32'he23a_a19c));
        rst = 1'b1;
        sub_vld = 1'b0;
        sub_lck = 1'b0;
        sub_ndn = 1'b0;
        sub_wen = 1'b0;
        sub_adr = '0;
        sub_siz = '0;
        sub_byt = 4'hf;  // unused in size mode
        sub_wdt = '0;
        chk = 1'b0;
        n_sent = 0;
        n_checked = 0;
        shd_wp = 1'b0;
        shd_scr = '0;
        shd_cnt = '0;
        repeat (3) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        @(posedge clk);
        if (sub_rdy !== 1'b1)
            stop_run($sformatf("[ERROR] %0t ns: sub_rdy low after reset", $time));

        // 1. identifier, counter and control after reset
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE + 12, 2'd2, '0);
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE + 8, 2'd2, '0);
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE, 2'd2, '0);

        // known memory contents first
        for (int i = 0; i < `TCB_MEM_WORDS; i++)
            drive_req(1'b1, 1'b0, `TCB_MEM_BASE + 4 * i, 2'd2, fill_pattern(i));

        // 2. every size, offset and endianness with a write, a same-size read and a word read
        sel = 0;
        for (int n = 0; n < 2; n++) begin
            for (int s = 0; s < 3; s++) begin
                for (int o = 0; o < 4; o += (1 << s)) begin
                    adr = 32'h200 + 4 * sel;
                    drive_req(1'b1, n[0], adr + o, s[1:0], $urandom);
                    drive_req(1'b0, n[0], adr + o, s[1:0], '0);
                    drive_req(1'b0, 1'b0, adr, 2'd2, '0);
                    sel++;
                end
            end
        end

        // 3. misaligned half and word accesses and then addresses outside both windows
        for (int s = 1; s < 3; s++) begin
            for (int o = 1; o < 4; o++) begin
                if (!(s == 1 && o == 2)) begin
                    adr = 32'h300 + 4 * o + 16 * s;
                    drive_req(1'b1, 1'b0, adr + o, s[1:0], 32'hbad0_bad0);
                    drive_req(1'b0, 1'b0, adr + o, s[1:0], '0);
                    drive_req(1'b0, 1'b0, adr, 2'd2, '0);  // still the old word
                end
            end
        end
        foreach (sel_adr_list[j]) begin
            drive_req(1'b1, 1'b0, sel_adr_list[j], 2'd2, 32'h5555_aaaa);
            drive_req(1'b0, 1'b0, sel_adr_list[j], 2'd2, '0);
        end

        // 4. write protect blocks memory writes while reads still go
        drive_req(1'b1, 1'b0, `TCB_CSR_BASE, 2'd2, 32'h1);
        drive_req(1'b1, 1'b0, 32'h10, 2'd2, 32'hdead_beef);
        drive_req(1'b0, 1'b0, 32'h10, 2'd2, '0);
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE, 2'd2, '0);
        drive_req(1'b1, 1'b0, `TCB_CSR_BASE, 2'd0, 32'h0);  // byte write clears wp
        drive_req(1'b1, 1'b0, 32'h10, 2'd2, 32'hdead_beef);
        drive_req(1'b0, 1'b0, 32'h10, 2'd2, '0);

        // 5. counter and scratch byte enables
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE + 8, 2'd2, '0);
        drive_req(1'b1, 1'b0, `TCB_CSR_BASE + 4, 2'd2, 32'h1111_1111);
        drive_req(1'b1, 1'b0, `TCB_CSR_BASE + 6, 2'd0, 32'h0000_00ab);
        drive_req(1'b1, 1'b1, `TCB_CSR_BASE + 4, 2'd1, 32'h0000_1234);
        drive_req(1'b0, 1'b0, `TCB_CSR_BASE + 4, 2'd2, '0);

        // 6. random back-to-back traffic that is mostly aligned
        for (int t = 0; t < 400; t++) begin
            if ($urandom % 8 == 0) idle_cycle();
            sel = $urandom % 10;
            siz = $urandom % 3;
            if (sel < 7)      adr = `TCB_MEM_BASE + ($urandom % (4 * `TCB_MEM_WORDS));
            else if (sel < 9) adr = `TCB_CSR_BASE + ($urandom % 16);
            else              adr = $urandom;
            if ($urandom % 8 != 0) adr = adr & ~((32'd1 << siz) - 32'd1);
            drive_req($urandom % 2, $urandom % 2, adr, siz, $urandom);
        end

        idle_cycle();
        idle_cycle();  // last response compared
        if ((n_checked == n_sent) && (exp_q.size() == 0)) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("responses missing: %0d transfers, %0d compared", n_sent, n_checked);
            $display("** FAIL **");
            $fatal(1, "response count mismatch");
        end
    end

endmodule: tcb_lite_tb

// ==== design/tcb_lite_top.sv ====
// tcb-lite subordinate top: flat port to converter, decoder, memory and registers
`timescale 1ns/1ns

module tcb_lite_top (
    // system
    input  logic                   clk,      // clock
    input  logic                   rst,      // reset, sync active high
    // subordinate port
    input  logic                   sub_vld,  // handshake valid
    input  logic                   sub_lck,  // arbitration lock
    input  logic                   sub_ndn,  // endianness
    input  logic                   sub_wen,  // write enable
    input  tcb_lite_pkg::tcb_adr_t sub_adr,  // address
    input  tcb_lite_pkg::tcb_siz_t sub_siz,  // logarithmic size
    input  tcb_lite_pkg::tcb_byt_t sub_byt,  // byte enables
    input  tcb_lite_pkg::tcb_dat_t sub_wdt,  // write data
    output logic                   sub_rdy,  // handshake ready
    output tcb_lite_pkg::tcb_dat_t sub_rdt,  // read data
    output logic                   sub_err   // bus error
);

    //////////////////////////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////////////////////////

    tcb_lite_pkg::tcb_req_t req_sub;  // as it arrives
    tcb_lite_pkg::tcb_req_t req_ali;  // lane aligned, byte enabled
    tcb_lite_pkg::tcb_rsp_t rsp_ali;  // from decoder, lane aligned
    tcb_lite_pkg::tcb_rsp_t rsp_sub;  // restored to bit 0

    // memory strobes
    logic                   mem_vld;
    logic                   mem_wen;
    tcb_lite_pkg::mem_idx_t mem_idx;
    tcb_lite_pkg::tcb_byt_t mem_byt;
    tcb_lite_pkg::tcb_dat_t mem_wdt;
    tcb_lite_pkg::tcb_dat_t mem_rdt;
    logic                   mem_wr_done;  // accepted memory write

    // register strobes
    logic                   csr_vld;
    logic                   csr_wen;
    tcb_lite_pkg::csr_idx_t csr_idx;
    tcb_lite_pkg::tcb_byt_t csr_byt;
    tcb_lite_pkg::tcb_dat_t csr_wdt;
    tcb_lite_pkg::tcb_dat_t csr_rdt;
    logic                   wp;  // memory write protect

    //////////////////////////////////////////////////////////////////////
    // port packing
    //////////////////////////////////////////////////////////////////////

    assign req_sub.vld = sub_vld;
    assign req_sub.lck = sub_lck;
    assign req_sub.ndn = sub_ndn;
    assign req_sub.wen = sub_wen;
    assign req_sub.adr = sub_adr;
    assign req_sub.siz = sub_siz;
    assign req_sub.byt = sub_byt;
    assign req_sub.wdt = sub_wdt;
    assign req_sub.mis = 1'b0;  // only the converter raises it

    assign sub_rdt = rsp_sub.rdt;
    assign sub_err = rsp_sub.err;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    tcb_lite_lib_logsize2byteena cnv (
        .clk (clk), .rst (rst),
        .req_i (req_sub), .req_o (req_ali),
        .rsp_i (rsp_ali), .rsp_o (rsp_sub)
    );

    tcb_lite_lib_decoder dec (
        .clk (clk), .rst (rst),
        .req (req_ali), .rdy (sub_rdy), .rsp (rsp_ali),
        .mem_vld (mem_vld), .mem_wen (mem_wen), .mem_idx (mem_idx),
        .mem_byt (mem_byt), .mem_wdt (mem_wdt), .mem_rdt (mem_rdt),
        .mem_wr_done (mem_wr_done),
        .csr_vld (csr_vld), .csr_wen (csr_wen), .csr_idx (csr_idx),
        .csr_byt (csr_byt), .csr_wdt (csr_wdt), .csr_rdt (csr_rdt),
        .wp (wp)
    );

    tcb_lite_mem mem (
        .clk (clk),
        .vld (mem_vld), .wen (mem_wen), .idx (mem_idx),
        .byt (mem_byt), .wdt (mem_wdt), .rdt (mem_rdt)
    );

    // register block beside the memory, steers it through wp
    tcb_lite_csr csr (
        .clk (clk), .rst (rst),
        .vld (csr_vld), .wen (csr_wen), .idx (csr_idx),
        .byt (csr_byt), .wdt (csr_wdt), .rdt (csr_rdt),
        .mem_wr_done (mem_wr_done), .wp (wp)
    );

endmodule: tcb_lite_top

// ==== design/tcb_lite_csr.sv ====
// tcb-lite register block: write protect, scratch, memory write counter, identifier
`timescale 1ns/1ns
`include "tcb_lite_settings.svh"

module tcb_lite_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   vld,          // access strobe from decoder
    input  logic                   wen,          // write enable
    input  tcb_lite_pkg::csr_idx_t idx,          // register index
    input  tcb_lite_pkg::tcb_byt_t byt,          // byte enables
    input  tcb_lite_pkg::tcb_dat_t wdt,          // write data
    output tcb_lite_pkg::tcb_dat_t rdt,          // read data, next cycle
    input  logic                   mem_wr_done,  // one accepted memory write
    output logic                   wp            // memory write protect
);

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////
    // 0 control, bit 0 wp
    // 1 scratch, byte writable
    // 2 memory write counter, read only
    // 3 identifier, read only

    tcb_lite_pkg::tcb_dat_t scr;  // scratch word
    tcb_lite_pkg::tcb_dat_t cnt;  // memory write count

    logic wr_ctl;
    logic wr_scr;

    assign wr_ctl = vld & wen & (idx == 2'd0) & byt[0];  // wp lives in lane 0
    assign wr_scr = vld & wen & (idx == 2'd1);

    //////////////////////////////////////////////////////////////////////
    // writable state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wp  <= 1'b0;
            scr <= '0;
            cnt <= '0;
        end else begin
            if (wr_ctl) wp <= wdt[0];
            if (wr_scr) begin
                for (int b = 0; b < $bits(tcb_lite_pkg::tcb_byt_t); b++) begin
                    if (byt[b]) scr[8*b +: 8] <= wdt[8*b +: 8];
                end
            end
            if (mem_wr_done) cnt <= cnt + 32'd1;  // wraps at 2^32
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux
    //////////////////////////////////////////////////////////////////////

    // writes to 2 and 3 just fall through, no error
    always_ff @(posedge clk) begin
        if (vld && !wen) begin
            case (idx)
                2'd0:    rdt <= {31'd0, wp};
                2'd1:    rdt <= scr;
                2'd2:    rdt <= cnt;
                default: rdt <= `TCB_CSR_ID;
            endcase
        end
    end

    // decoder must block memory writes while protected
    a_wp_block: assert property (@(posedge clk) disable iff (rst)
        mem_wr_done |-> !wp);

endmodule: tcb_lite_csr

// ==== design/tcb_lite_mem.sv ====
// tcb-lite memory: byte-writable word array, one-cycle registered read
`timescale 1ns/1ns
`include "tcb_lite_settings.svh"

module tcb_lite_mem (
    input  logic                   clk,
    input  logic                   vld,  // access strobe from decoder
    input  logic                   wen,  // write enable
    input  tcb_lite_pkg::mem_idx_t idx,  // word index
    input  tcb_lite_pkg::tcb_byt_t byt,  // byte enables
    input  tcb_lite_pkg::tcb_dat_t wdt,  // write data, lane aligned
    output tcb_lite_pkg::tcb_dat_t rdt   // read data, next cycle
);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    tcb_lite_pkg::tcb_dat_t mem [0:`TCB_MEM_WORDS-1];  // contents undefined until written

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    // each enabled lane separately
    always_ff @(posedge clk) begin
        if (vld && wen) begin
            for (int b = 0; b < $bits(tcb_lite_pkg::tcb_byt_t); b++) begin
                if (byt[b]) begin
                    mem[idx][8*b +: 8] <= wdt[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // registered, holds between reads
    always_ff @(posedge clk) begin
        if (vld && !wen) begin
            rdt <= mem[idx];
        end
    end

endmodule: tcb_lite_mem

// ==== design/tcb_lite_lib_decoder.sv ====
// tcb-lite address decoder that routes to memory or registers, checks errors and muxes the response
`timescale 1ns/1ns
`include "tcb_lite_settings.svh"

module tcb_lite_lib_decoder (
    input  logic                   clk,
    input  logic                   rst,
    // upstream
    input  tcb_lite_pkg::tcb_req_t req,
    output logic                   rdy,
    output tcb_lite_pkg::tcb_rsp_t rsp,
    // memory
    output logic                   mem_vld,
    output logic                   mem_wen,
    output tcb_lite_pkg::mem_idx_t mem_idx,
    output tcb_lite_pkg::tcb_byt_t mem_byt,
    output tcb_lite_pkg::tcb_dat_t mem_wdt,
    input  tcb_lite_pkg::tcb_dat_t mem_rdt,
    output logic                   mem_wr_done,  // write took effect
    // registers
    output logic                   csr_vld,
    output logic                   csr_wen,
    output tcb_lite_pkg::csr_idx_t csr_idx,
    output tcb_lite_pkg::tcb_byt_t csr_byt,
    output tcb_lite_pkg::tcb_dat_t csr_wdt,
    input  tcb_lite_pkg::tcb_dat_t csr_rdt,
    input  logic                   wp  // memory write protect
);

    tcb_lite_pkg::tcb_adr_t mem_off;  // address relative to memory base
    tcb_lite_pkg::tcb_adr_t csr_off;  // relative to register base
    logic hit_mem;
    logic hit_csr;
    logic trn;      // transfer this cycle
    logic err_now;  // transfer would fail
    logic sel_mem_q;
    logic sel_csr_q;
    logic err_q;

    //////////////////////////////////////////////////////////////////////
    // decode and error rules
    //////////////////////////////////////////////////////////////////////

    assign rdy = ~rst;  // never back-pressure outside reset
    assign trn = req.vld & rdy;

    assign mem_off = req.adr - `TCB_MEM_BASE;
    assign csr_off = req.adr - `TCB_CSR_BASE;
    assign hit_mem = mem_off < (`TCB_MEM_WORDS * 4);
    assign hit_csr = (csr_off[31:4] == '0);  // 4 registers

    assign err_now = ~(hit_mem | hit_csr)        // unmapped
                   | req.mis                     // misaligned size
                   | (hit_mem & req.wen & wp);  // protected memory

    // target strobes for clean transfers only
    assign mem_vld     = trn & hit_mem & ~err_now;
    assign mem_wen     = req.wen;
    assign mem_idx     = mem_off[$bits(tcb_lite_pkg::mem_idx_t)+1:2];
    assign mem_byt     = req.byt;
    assign mem_wdt     = req.wdt;
    assign mem_wr_done = mem_vld & req.wen;

    assign csr_vld = trn & hit_csr & ~err_now;
    assign csr_wen = req.wen;
    assign csr_idx = csr_off[3:2];
    assign csr_byt = req.byt;
    assign csr_wdt = req.wdt;

    //////////////////////////////////////////////////////////////////////
    // response stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_mem_q <= 1'b0;
            sel_csr_q <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            sel_mem_q <= mem_vld;  // which target answers next cycle
            sel_csr_q <= csr_vld;
            err_q     <= trn & err_now;
        end
    end

    always_comb begin
        rsp.err = err_q;
        if (err_q)          rsp.rdt = '0;  // failed reads return 0
        else if (sel_mem_q) rsp.rdt = mem_rdt;
        else if (sel_csr_q) rsp.rdt = csr_rdt;
        else                rsp.rdt = '0;
    end

    // one target at a time
    a_one_hot: assert property (@(posedge clk) !(mem_vld && csr_vld));
    // no transfer accepted in reset
    a_rst_rdy: assert property (@(posedge clk) rst |-> !rdy);

endmodule: tcb_lite_lib_decoder

// ==== design/tcb_lite_lib_logsize2byteena.sv ====
// tcb-lite size converter: logarithmic size to byte enables, lane and byte order steering
`timescale 1ns/1ns
`include "tcb_lite_settings.svh"

module tcb_lite_lib_logsize2byteena (
    input  logic                   clk,
    input  logic                   rst,
    input  tcb_lite_pkg::tcb_req_t req_i,  // upstream request
    output tcb_lite_pkg::tcb_req_t req_o,  // aligned request
    input  tcb_lite_pkg::tcb_rsp_t rsp_i,  // aligned response
    output tcb_lite_pkg::tcb_rsp_t rsp_o   // upstream response
);

    // reverse byte order inside the transfer size, result from bit 0
    function automatic tcb_lite_pkg::tcb_dat_t swap_bytes(
        input tcb_lite_pkg::tcb_dat_t dat,
        input tcb_lite_pkg::tcb_siz_t siz
    );
        case (siz)
            2'd0:    return dat;  // single byte, nothing to swap
            2'd1:    return {dat[31:16], dat[7:0], dat[15:8]};
            default: return {dat[7:0], dat[15:8], dat[23:16], dat[31:24]};
        endcase
    endfunction

    logic             [1:0] off;      // byte offset in word
    tcb_lite_pkg::tcb_byt_t byt_lin;  // enables before shift
    tcb_lite_pkg::tcb_dat_t wdt_swp;  // write data, byte order fixed
    tcb_lite_pkg::tcb_dat_t rdt_shf;  // read data back at bit 0
    tcb_lite_pkg::tcb_dat_t rdt_msk;  // bytes above size cleared
    logic             [1:0] off_q;    // offset of the transfer in flight
    tcb_lite_pkg::tcb_siz_t siz_q;
    logic                   ndn_q;

    //////////////////////////////////////////////////////////////////////
    // request path, combinational
    //////////////////////////////////////////////////////////////////////

    assign off     = req_i.adr[1:0];
    assign byt_lin = (req_i.siz == 2'd0) ? 4'b0001 :
                     (req_i.siz == 2'd1) ? 4'b0011 : 4'b1111;
    assign wdt_swp = req_i.ndn ? swap_bytes(req_i.wdt, req_i.siz) : req_i.wdt;

    always_comb begin
        req_o = req_i;  // handshake, address, size pass as is
        if (`TCB_MOD == 0) begin
            req_o.byt = byt_lin << off;
            req_o.wdt = wdt_swp << {off, 3'b000};  // into addressed lanes
            req_o.mis = ((req_i.siz == 2'd1) && off[0]) ||
                        ((req_i.siz >= 2'd2) && (off != 2'd0));
        end
    end

    // size info for the response cycle
    always_ff @(posedge clk) begin
        if (req_i.vld) begin
            off_q <= off;
            siz_q <= req_i.siz;
            ndn_q <= req_i.ndn;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response path
    //////////////////////////////////////////////////////////////////////

    assign rdt_shf = rsp_i.rdt >> {off_q, 3'b000};
    assign rdt_msk = rdt_shf & ((siz_q == 2'd0) ? 32'h0000_00ff :
                                (siz_q == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff);

    always_comb begin
        rsp_o = rsp_i;  // byte-enable mode: lanes untouched
        if (`TCB_MOD == 0) begin
            rsp_o.rdt = ndn_q ? swap_bytes(rdt_msk, siz_q) : rdt_msk;
        end
    end

    // upstream size must fit in the 32-bit bus
    a_siz_max: assert property (@(posedge clk) disable iff (rst)
        ((`TCB_MOD == 0) && req_i.vld) |-> (req_i.siz <= 2'd2));

endmodule: tcb_lite_lib_logsize2byteena

// ==== design/tcb_lite_pkg.sv ====
// tcb-lite types: width typedefs and the request/response structs
package tcb_lite_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths with a meaning
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] tcb_adr_t;  // byte address
    typedef logic [31:0] tcb_dat_t;  // data word
    typedef logic  [3:0] tcb_byt_t;  // byte enables, one per lane
    typedef logic  [1:0] tcb_siz_t;  // log2 of transfer bytes
    typedef logic  [7:0] mem_idx_t;  // memory word index
    typedef logic  [1:0] csr_idx_t;  // register index

    //////////////////////////////////////////////////////////////////////
    // bus structs
    //////////////////////////////////////////////////////////////////////

    // request, one transfer
    typedef struct packed {
        logic     vld;  // handshake valid
        logic     lck;  // arbitration lock, carried only
        logic     ndn;  // endianness (0-little, 1-big)
        logic     wen;  // write enable (0-read, 1-write)
        tcb_adr_t adr;  // address
        tcb_siz_t siz;  // logarithmic size
        tcb_byt_t byt;  // byte enables
        tcb_dat_t wdt;  // write data
        logic     mis;  // misaligned, set by the size converter
    } tcb_req_t;

    // response, valid one cycle after the transfer
    typedef struct packed {
        tcb_dat_t rdt;  // read data
        logic     err;  // bus error
    } tcb_rsp_t;

endpackage: tcb_lite_pkg

// ==== design/tcb_lite_settings.svh ====
// tcb-lite subsystem settings: bus mode, response delay and memory map
`ifndef TCB_LITE_SETTINGS_SVH
`define TCB_LITE_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// bus configuration
//////////////////////////////////////////////////////////////////////

`define TCB_MOD 0  // bus mode (0-logarithmic size, 1-byte enable)
`define TCB_DLY 1  // response delay in cycles

//////////////////////////////////////////////////////////////////////
// memory map
//////////////////////////////////////////////////////////////////////

`define TCB_MEM_BASE  32'h0000_0000  // memory window base
`define TCB_MEM_WORDS 256            // memory depth in 32-bit words
`define TCB_CSR_BASE  32'h0000_1000  // register block base, 4 words
`define TCB_CSR_ID    32'h7C8B_0001  // identifier register value

`endif
